// File: project.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/itim_ram.sv
hdl/btac_table.sv
hdl/fetch_stage.sv
hdl/fetch_unit.sv
verification/tb_clock.sv
verification/fetch_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= fetch_unit_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/fetch_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_unit_tb;
  import fetch_pkg::*;

  localparam int DEPTH = 1 << `ITIM_INDEX_W;

  logic clock;
  logic reset;
  redirect_t redirect;
  resolve_t resolve;
  logic stall;
  logic load_valid;
  itim_index_t load_index;
  fetch_data_t load_data;
  fetch_packet_t packet;

  fetch_data_t image [DEPTH];
  int error_count;
  int timeout_count;

  tb_clock clock0 (
    .clock (clock),
    .reset (reset)
  );

  fetch_unit dut0 (
    .clock      (clock),
    .reset      (reset),
    .redirect   (redirect),
    .resolve    (resolve),
    .stall      (stall),
    .load_valid (load_valid),
    .load_index (load_index),
    .load_data  (load_data),
    .packet     (packet)
  );

  // fibonacci lfsr with taps 32 22 2 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic build_image();
    logic [31:0] state;
    fetch_data_t word;
    int i;
    int b;
    state = 32'h5c42fdd6;
    for (i = 0; i < DEPTH; i++) begin
      for (b = 0; b < `FETCH_DATA_W; b++) begin
        state = lfsr_next(state);
        word[b] = state[0];
      end
      image[i] = word;
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #2;
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      error_count++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input fetch_data_t got, input fetch_data_t exp);
    if (got !== exp) begin
      error_count++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    @(posedge clock);
    while (reset !== 1'b1 && n < 64) begin
      n++;
      @(posedge clock);
    end
    if (reset !== 1'b1) begin
      timeout_count++;
      $display("reset was never released");
    end
  endtask

  // fetch is held in clear while the memory is filled.
  task automatic preload_memory();
    int i;
    for (i = 0; i < DEPTH; i++) begin
      next_cycle();
      load_valid = 1'b1;
      load_index = itim_index_t'(i);
      load_data = image[i];
    end
    next_cycle();
    load_valid = 1'b0;
  endtask

  // waits for the next packet.
  // low and high bound the empty cycles before it.
  task automatic expect_packet(input addr_t exp_pc, input logic exp_taken,
                               input int low, input int high);
    int waited;
    waited = 0;
    @(negedge clock);
    while (!packet.valid && waited < high + 4) begin
      waited++;
      @(negedge clock);
    end
    if (!packet.valid) begin
      timeout_count++;
      $display("no packet for pc %h within %0d cycles", exp_pc, waited);
    end else begin
      if (waited < low || waited > high) begin
        error_count++;
        $display("packet for pc %h came after %0d empty cycles, expected %0d to %0d",
                 exp_pc, waited, low, high);
      end
      check_addr("packet.pc", packet.pc, exp_pc);
      check_data("packet.rdata", packet.rdata, image[exp_pc[3 +: `ITIM_INDEX_W]]);
      check_bit("packet.taken", packet.taken, exp_taken);
    end
  endtask

  task automatic strobe_redirect(input logic trap, input logic mret, input logic fence,
                                 input addr_t mtvec, input addr_t mepc, input addr_t npc);
    next_cycle();
    redirect.trap = trap;
    redirect.mret = mret;
    redirect.fence = fence;
    redirect.mtvec = mtvec;
    redirect.mepc = mepc;
    redirect.fence_npc = npc;
    next_cycle();
    redirect.trap = 1'b0;
    redirect.mret = 1'b0;
    redirect.fence = 1'b0;
  endtask

  task automatic strobe_resolve(input addr_t pc, input addr_t target, input logic taken,
                                input logic pred_taken, input addr_t pred_taddr);
    next_cycle();
    resolve.valid = 1'b1;
    resolve.pc = pc;
    resolve.target = target;
    resolve.taken = taken;
    resolve.pred_taken = pred_taken;
    resolve.pred_taddr = pred_taddr;
    next_cycle();
    resolve.valid = 1'b0;
  endtask

  task automatic test_sequential();
    int k;
    next_cycle();
    redirect.clear = 1'b0;
    expect_packet(32'h0, 1'b0, 1, 1);
    for (k = 1; k < 8; k++) begin
      expect_packet(addr_t'(8 * k), 1'b0, 0, 0);
    end
  endtask

  task automatic test_trap_mret();
    strobe_redirect(1'b1, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0200, 32'h0);
    expect_packet(32'h0000_0100, 1'b0, 0, 0);
    // trap beats mret in the same cycle.
    strobe_redirect(1'b1, 1'b1, 1'b0, 32'h0000_0180, 32'h0000_02c0, 32'h0);
    expect_packet(32'h0000_0180, 1'b0, 0, 0);
    strobe_redirect(1'b0, 1'b1, 1'b0, 32'h0000_0180, 32'h0000_03a8, 32'h0);
    expect_packet(32'h0000_03a8, 1'b0, 0, 0);
  endtask

  task automatic test_stall(input addr_t last_pc);
    addr_t held_pc;
    int k;
    held_pc = last_pc + addr_t'(8);
    next_cycle();
    stall = 1'b1;
    for (k = 0; k < 4; k++) begin
      @(negedge clock);
      check_bit("packet.valid", packet.valid, 1'b0);
      check_addr("packet.pc", packet.pc, held_pc);
      next_cycle();
    end
    stall = 1'b0;
    expect_packet(held_pc, 1'b0, 0, 0);
  endtask

  task automatic test_prediction();
    strobe_resolve(32'h0000_0500, 32'h0000_0640, 1'b1, 1'b1, 32'h0000_0640);
    strobe_redirect(1'b1, 1'b0, 1'b0, 32'h0000_0500, 32'h0, 32'h0);
    expect_packet(32'h0000_0500, 1'b1, 0, 0);
    check_addr("packet.taddr", packet.taddr, 32'h0000_0640);
    check_addr("packet.tpc", packet.tpc, 32'h0000_0500);
    expect_packet(32'h0000_0640, 1'b0, 0, 0);
    strobe_resolve(32'h0000_0500, 32'h0000_0640, 1'b0, 1'b0, 32'h0);
    strobe_redirect(1'b1, 1'b0, 1'b0, 32'h0000_0500, 32'h0, 32'h0);
    expect_packet(32'h0000_0500, 1'b0, 0, 0);
    expect_packet(32'h0000_0508, 1'b0, 0, 0);
  endtask

  task automatic test_mispredict_clear();
    int k;
    // predicted taken but fell through, so fetch resumes after the branch.
    strobe_resolve(32'h0000_06a4, 32'h0000_0780, 1'b0, 1'b1, 32'h0000_0780);
    expect_packet(32'h0000_06a8, 1'b0, 0, 0);
    strobe_resolve(32'h0000_0620, 32'h0000_0700, 1'b1, 1'b0, 32'h0);
    expect_packet(32'h0000_0700, 1'b0, 0, 0);
    strobe_redirect(1'b1, 1'b0, 1'b0, 32'h0000_0620, 32'h0, 32'h0);
    expect_packet(32'h0000_0620, 1'b1, 0, 0);
    next_cycle();
    redirect.clear = 1'b1;
    for (k = 0; k < 4; k++) begin
      @(negedge clock);
      check_bit("packet.valid", packet.valid, 1'b0);
      next_cycle();
    end
    redirect.clear = 1'b0;
    strobe_redirect(1'b1, 1'b0, 1'b0, 32'h0000_0620, 32'h0, 32'h0);
    expect_packet(32'h0000_0620, 1'b0, 0, 0);
  endtask

  // the request goes out in the strobe cycle, so the empty cycles are one less.
  task automatic test_fence();
    strobe_redirect(1'b0, 1'b0, 1'b1, 32'h0, 32'h0, 32'h0000_07c0);
    expect_packet(32'h0000_07c0, 1'b0, `ITIM_FENCE_CYCLES, `ITIM_FENCE_CYCLES + 4);
  endtask

  initial begin
    redirect = '0;
    redirect.clear = 1'b1;
    resolve = '0;
    stall = 1'b0;
    load_valid = 1'b0;
    load_index = '0;
    load_data = '0;
    error_count = 0;
    timeout_count = 0;
    build_image();
    wait_reset_release();
    preload_memory();
    test_sequential();
    test_trap_mret();
    test_stall(32'h0000_03a8);
    test_prediction();
    test_mispredict_clear();
    test_fence();
    $display("value errors %0d, timeouts %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int HALF_PERIOD = 10,
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  // reset is active low and lets go just after a rising edge.
  initial begin
    reset = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    reset = 1'b1;
  end

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire fetch_pkg::redirect_t   redirect,
  input  wire fetch_pkg::resolve_t    resolve,
  input  wire logic                   stall,
  input  wire logic                   load_valid,
  input  wire fetch_pkg::itim_index_t load_index,
  input  wire fetch_pkg::fetch_data_t load_data,
  output fetch_pkg::fetch_packet_t    packet
);
  import fetch_pkg::*;

  btac_in_t btac_in;
  btac_out_t btac_out;
  itim_req_t itim_req;
  itim_rsp_t itim_rsp;

  fetch_stage fetch_stage0 (
    .clock    (clock),
    .reset    (reset),
    .redirect (redirect),
    .resolve  (resolve),
    .stall    (stall),
    .btac_out (btac_out),
    .btac_in  (btac_in),
    .itim_rsp (itim_rsp),
    .itim_req (itim_req),
    .packet   (packet)
  );

  btac_table btac_table0 (
    .clock    (clock),
    .reset    (reset),
    .btac_in  (btac_in),
    .btac_out (btac_out)
  );

  itim_ram itim_ram0 (
    .clock      (clock),
    .reset      (reset),
    .load_valid (load_valid),
    .load_index (load_index),
    .load_data  (load_data),
    .req        (itim_req),
    .rsp        (itim_rsp)
  );

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire fetch_pkg::redirect_t redirect,
  input  wire fetch_pkg::resolve_t  resolve,
  input  wire logic                 stall,
  input  wire fetch_pkg::btac_out_t btac_out,
  output fetch_pkg::btac_in_t       btac_in,
  input  wire fetch_pkg::itim_rsp_t itim_rsp,
  output fetch_pkg::itim_req_t      itim_req,
  output fetch_pkg::fetch_packet_t  packet
);
  import fetch_pkg::*;

  fetch_state_t state_q;
  fetch_state_t state_d;
  addr_t pc_q;
  addr_t pc_d;

  logic advance;
  logic issue;
  logic spec;
  logic fence;
  logic taken;
  addr_t taddr;
  addr_t tpc;

  // the response for pc_q is consumed only in busy, unstalled and not cleared.
  assign advance = (state_q == busy) && itim_rsp.ready && !stall && !redirect.clear;

  // next pc.
  always_comb begin
    pc_d = pc_q;
    spec = 1'b0;
    fence = 1'b0;
    taken = 1'b0;
    taddr = '0;
    tpc = '0;

    if (redirect.trap) begin
      pc_d = redirect.mtvec;
      spec = 1'b1;
    end else if (redirect.mret) begin
      pc_d = redirect.mepc;
      spec = 1'b1;
    end else if (btac_out.pred_miss) begin
      pc_d = btac_out.pred_maddr;
      spec = 1'b1;
    end else if (redirect.fence) begin
      pc_d = redirect.fence_npc;
      spec = 1'b1;
      fence = 1'b1;
    end else if (advance && btac_out.pred_branch) begin
      pc_d = btac_out.pred_baddr;
      taken = 1'b1;
      taddr = btac_out.pred_baddr;
      tpc = btac_out.pred_pc;
    end else if (advance) begin
      pc_d = pc_q + addr_t'(8);
    end
  end

  // request machine.
  always_comb begin
    state_d = state_q;
    issue = 1'b0;

    case (state_q)
      idle: begin
        state_d = busy;
        issue = 1'b1;
      end
      busy: begin
        // while stalled the same pc is fetched again, so nothing is lost.
        if (itim_rsp.ready) begin
          issue = 1'b1;
        end else if (fence) begin
          state_d = inv;
        end else if (spec) begin
          state_d = ctrl;
        end
      end
      ctrl: begin
        if (itim_rsp.ready) begin
          state_d = busy;
          issue = 1'b1;
        end else if (fence) begin
          state_d = inv;
        end
      end
      inv: begin
        if (itim_rsp.ready) begin
          state_d = busy;
          issue = 1'b1;
        end
      end
      default: begin
        state_d = idle;
      end
    endcase

    if (redirect.clear) begin
      state_d = idle;
      issue = 1'b0;
    end
  end

  // a pending invalidate is carried by inv until its request goes out.
  always_comb begin
    itim_req.valid = issue;
    itim_req.fence = fence || (state_q == inv);
    itim_req.spec = spec || (state_q != busy);
    itim_req.addr = pc_d;
  end

  // the fetch arriving with a redirect is on the wrong path.
  always_comb begin
    packet.valid = advance && !spec;
    packet.pc = pc_q;
    packet.rdata = itim_rsp.rdata;
    packet.taken = taken;
    packet.taddr = taddr;
    packet.tpc = tpc;
  end

  always_comb begin
    btac_in.get_pc = pc_q;
    btac_in.resolve = resolve;
    btac_in.clear = redirect.clear;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= idle;
      pc_q <= '0;
    end else begin
      state_q <= state_d;
      pc_q <= pc_d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/btac_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module btac_table (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire fetch_pkg::btac_in_t  btac_in,
  output fetch_pkg::btac_out_t      btac_out
);
  import fetch_pkg::*;

  localparam int DEPTH = 1 << `BTAC_INDEX_W;
  localparam int TAG_LSB = 3 + `BTAC_INDEX_W;
  localparam int TAG_W = `FETCH_ADDR_W - TAG_LSB;

  logic [DEPTH-1:0] entry_valid;
  logic [TAG_W-1:0] entry_tag [DEPTH];
  addr_t entry_target [DEPTH];

  resolve_t res;
  logic [`BTAC_INDEX_W-1:0] get_index;
  logic [`BTAC_INDEX_W-1:0] upd_index;
  logic [TAG_W-1:0] get_tag;
  logic [TAG_W-1:0] upd_tag;
  logic upd_match;
  logic target_differs;

  assign res = btac_in.resolve;

  // both slots of a pair share one entry.
  assign get_index = btac_in.get_pc[3 +: `BTAC_INDEX_W];
  assign get_tag = btac_in.get_pc[`FETCH_ADDR_W-1:TAG_LSB];
  assign upd_index = res.pc[3 +: `BTAC_INDEX_W];
  assign upd_tag = res.pc[`FETCH_ADDR_W-1:TAG_LSB];

  assign upd_match = entry_valid[upd_index] && (entry_tag[upd_index] == upd_tag);

  // lookup of the registered fetch pc.
  always_comb begin
    btac_out.pred_branch = entry_valid[get_index] && (entry_tag[get_index] == get_tag);
    btac_out.pred_baddr = entry_target[get_index];
    btac_out.pred_pc = btac_in.get_pc;
  end

  // mispredict check on the resolve strobe.
  always_comb begin
    target_differs = res.target != res.pred_taddr;
    btac_out.pred_miss = res.valid &&
                         ((res.taken != res.pred_taken) || (res.taken && target_differs));
    if (res.taken) begin
      btac_out.pred_maddr = res.target;
    end else begin
      btac_out.pred_maddr = res.pc + addr_t'(4);
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      entry_valid <= '0;
    end else if (btac_in.clear) begin
      entry_valid <= '0;
    end else if (res.valid) begin
      if (res.taken) begin
        entry_valid[upd_index] <= 1'b1;
      end else if (upd_match) begin
        entry_valid[upd_index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (res.valid && res.taken) begin
      entry_tag[upd_index] <= upd_tag;
      entry_target[upd_index] <= res.target;
    end
  end

endmodule

`default_nettype wire

// File: hdl/itim_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module itim_ram (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic                   load_valid,
  input  wire fetch_pkg::itim_index_t load_index,
  input  wire fetch_pkg::fetch_data_t load_data,
  input  wire fetch_pkg::itim_req_t   req,
  output fetch_pkg::itim_rsp_t        rsp
);
  import fetch_pkg::*;

  localparam int DEPTH = 1 << `ITIM_INDEX_W;
  localparam int COUNT_W = $clog2(`ITIM_FENCE_CYCLES + 1);

  fetch_data_t mem [DEPTH];
  fetch_data_t rdata_q;
  itim_index_t req_index;
  logic pending;
  logic [COUNT_W-1:0] count;

  // words are 8 bytes, so the index starts above bit 2.
  assign req_index = req.addr[3 +: `ITIM_INDEX_W];

  always_ff @(posedge clock) begin
    if (load_valid) begin
      mem[load_index] <= load_data;
    end
  end

  always_ff @(posedge clock) begin
    if (req.valid) begin
      rdata_q <= mem[req_index];
    end
  end

  // a new request replaces the one in flight.
  // a fence starts the invalidate wait and a speculative request drops any wait left over.
  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= 1'b0;
      count <= '0;
    end else if (req.valid) begin
      pending <= 1'b1;
      if (req.fence) begin
        count <= COUNT_W'(`ITIM_FENCE_CYCLES);
      end else if (req.spec) begin
        count <= '0;
      end else if (count != '0) begin
        count <= count - 1'b1;
      end
    end else if (count != '0) begin
      count <= count - 1'b1;
    end else if (pending) begin
      pending <= 1'b0;
    end
  end

  always_comb begin
    rsp.ready = pending && (count == '0);
    rsp.rdata = rdata_q;
  end

endmodule

`default_nettype wire

// File: hdl/fetch_pkg.sv
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

  typedef logic [`FETCH_ADDR_W-1:0] addr_t;
  typedef logic [`FETCH_DATA_W-1:0] fetch_data_t;
  typedef logic [`ITIM_INDEX_W-1:0] itim_index_t;

  // request machine of the fetch stage.
  typedef enum logic [1:0] {
    idle = 2'd0,
    busy = 2'd1,
    ctrl = 2'd2,
    inv  = 2'd3
  } fetch_state_t;

  // control from the rest of the core.
  typedef struct packed {
    logic  trap;
    logic  mret;
    logic  fence;
    addr_t mtvec;
    addr_t mepc;
    addr_t fence_npc;
    logic  clear;
  } redirect_t;

  // a branch resolved in execute, with the prediction it was fetched under.
  typedef struct packed {
    logic  valid;
    addr_t pc;
    addr_t target;
    logic  taken;
    logic  pred_taken;
    addr_t pred_taddr;
  } resolve_t;

  typedef struct packed {
    addr_t    get_pc;
    resolve_t resolve;
    logic     clear;
  } btac_in_t;

  typedef struct packed {
    logic  pred_branch;
    addr_t pred_baddr;
    addr_t pred_pc;
    logic  pred_miss;
    addr_t pred_maddr;
  } btac_out_t;

  typedef struct packed {
    logic  valid;
    logic  fence;
    logic  spec;
    addr_t addr;
  } itim_req_t;

  typedef struct packed {
    logic        ready;
    fetch_data_t rdata;
  } itim_rsp_t;

  typedef struct packed {
    logic        valid;
    addr_t       pc;
    fetch_data_t rdata;
    logic        taken;
    addr_t       taddr;
    addr_t       tpc;
  } fetch_packet_t;

endpackage

`default_nettype wire

// File: hdl/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// address and fetch pair widths.
`define FETCH_ADDR_W 32
`define FETCH_DATA_W 64

// btac holds 2**BTAC_INDEX_W entries.
`define BTAC_INDEX_W 4

// itim depth in 64-bit words, log2.
`define ITIM_INDEX_W 8

// extra wait on a fenced request to model the invalidate.
`define ITIM_FENCE_CYCLES 4

`endif
